//--- build.f
common/osram_cfg_pkg.sv
common/osram_bus_pkg.sv
src/rr_arbiter.sv
output_bus/output_bus_arbiter.sv
output_bus/output_sram_bank.sv
src/output_sram_subsystem.sv
verification/output_sram_tb.sv

//--- common/osram_bus_pkg.sv
`default_nettype none

package osram_bus_pkg;

    // ----------------------------------------------------------
    // requester to arbiter
    // ----------------------------------------------------------

    typedef struct packed {
        logic                                req;          // held until grant pulse
        logic                                grant_valid;  // single cycle after grant
        logic [osram_cfg_pkg::node_id_w-1:0] node_id;
        logic [osram_cfg_pkg::pe_tag_w-1:0]  pe_tag;
    } pe_req_t;

    typedef struct packed {
        logic                                req;
        logic                                grant_valid;  // one beat per cycle
        logic [osram_cfg_pkg::node_id_w-1:0] node_id;
        logic [osram_cfg_pkg::feat_w-1:0]    data;
        logic                                sos;
        logic                                eos;          // last write beat
    } wr_req_t;

    // ----------------------------------------------------------
    // arbiter and banks
    // ----------------------------------------------------------

    typedef struct packed {
        logic                                valid;
        logic                                rd_wr;        // 1 = write
        logic [osram_cfg_pkg::node_id_w-1:0] node_id;
        logic [osram_cfg_pkg::pe_tag_w-1:0]  pe_tag;
        logic [osram_cfg_pkg::feat_w-1:0]    data;
        logic                                wr_sos;
        logic                                wr_eos;
    } bank_cmd_t;

    typedef struct packed {
        logic                                valid;
        logic [osram_cfg_pkg::pe_tag_w-1:0]  pe_tag;
        logic [osram_cfg_pkg::node_id_w-1:0] node_id;
        logic [osram_cfg_pkg::feat_w-1:0]    data;
        logic                                sos;
        logic                                eos;          // also frees the bank
    } bank_resp_t;

endpackage

`default_nettype wire

//--- common/osram_cfg_pkg.sv
`default_nettype none

package osram_cfg_pkg;

    // ----------------------------------------------------------
    // node addressing
    // ----------------------------------------------------------

    localparam int node_id_w = 8;   // low bits bank, high bits row

    // ----------------------------------------------------------
    // feature rows
    // ----------------------------------------------------------

    localparam int feat_w     = 16;  // one feature word
    localparam int feat_words = 4;   // beats per row stream

    // routes a read response back to its edge PE
    localparam int pe_tag_w = 2;

endpackage

`default_nettype wire

//--- output_bus/output_bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module output_bus_arbiter #(
    parameter int num_edge_pe     = 2,
    parameter int num_vertex_unit = 2,
    parameter int num_banks       = 4
) (
    input  wire logic                                              clk,
    input  wire logic                                              reset,
    input  wire osram_bus_pkg::pe_req_t    [num_edge_pe-1:0]       pe_req,
    input  wire osram_bus_pkg::wr_req_t    [num_edge_pe-1:0]       edge_wr_req,
    input  wire osram_bus_pkg::wr_req_t    [num_vertex_unit-1:0]   vertex_wr_req,
    input  wire osram_bus_pkg::bank_resp_t [num_banks-1:0]         bank_resp,
    output osram_bus_pkg::bank_cmd_t       [num_banks-1:0]         bank_cmd,
    output logic [2*num_edge_pe+num_vertex_unit-1:0]               grants
);

    localparam int num_reqs = 2 * num_edge_pe + num_vertex_unit;
    localparam int bank_w   = $clog2(num_banks);

    osram_bus_pkg::bank_cmd_t [num_reqs-1:0]  req_cmd;     // every requester in bank form
    logic [num_reqs-1:0]                      req_on;
    logic [num_reqs-1:0][bank_w-1:0]          req_bank;
    logic [num_reqs-1:0]                      masked_reqs;
    logic [num_banks-1:0]                     bank_busy;
    logic [num_banks-1:0]                     busy_d;
    logic [num_banks-1:0]                     bank_claim;  // granted this cycle
    logic [num_banks-1:0]                     bank_hit;    // command in flight this cycle
    logic [num_banks-1:0]                     bank_release;
    osram_bus_pkg::bank_cmd_t [num_banks-1:0] cmd_d;
    logic                                     cmd_collision;
    logic                                     grant_to_busy;

    function automatic osram_bus_pkg::bank_cmd_t wr_to_cmd(osram_bus_pkg::wr_req_t w);
        osram_bus_pkg::bank_cmd_t c;
        c.valid   = w.grant_valid;
        c.rd_wr   = 1'b1;
        c.node_id = w.node_id;
        c.pe_tag  = '0;
        c.data    = w.data;
        c.wr_sos  = w.sos;
        c.wr_eos  = w.eos;
        return c;
    endfunction

    // ----------------------------------------------------------
    // flatten readers, edge writers and vertex writers
    // ----------------------------------------------------------

    always_comb begin
        for (int i = 0; i < num_edge_pe; i++) begin
            req_on[i]          = pe_req[i].req;
            req_cmd[i].valid   = pe_req[i].grant_valid;
            req_cmd[i].rd_wr   = 1'b0;
            req_cmd[i].node_id = pe_req[i].node_id;
            req_cmd[i].pe_tag  = pe_req[i].pe_tag;
            req_cmd[i].data    = '0;
            req_cmd[i].wr_sos  = 1'b0;
            req_cmd[i].wr_eos  = 1'b0;
        end
        for (int i = 0; i < num_edge_pe; i++) begin
            req_on[num_edge_pe+i]  = edge_wr_req[i].req;
            req_cmd[num_edge_pe+i] = wr_to_cmd(edge_wr_req[i]);
        end
        for (int i = 0; i < num_vertex_unit; i++) begin
            req_on[2*num_edge_pe+i]  = vertex_wr_req[i].req;
            req_cmd[2*num_edge_pe+i] = wr_to_cmd(vertex_wr_req[i]);
        end
    end

    // ----------------------------------------------------------
    // bank state and command steering
    // ----------------------------------------------------------

    always_comb begin
        bank_claim    = '0;
        bank_hit      = '0;
        cmd_d         = '0;
        cmd_collision = 1'b0;
        grant_to_busy = 1'b0;
        for (int i = 0; i < num_reqs; i++) begin
            req_bank[i] = req_cmd[i].node_id[bank_w-1:0];
            if (grants[i]) begin
                bank_claim[req_bank[i]] = 1'b1;
            end
            if (req_cmd[i].valid) begin
                cmd_collision = cmd_collision | bank_hit[req_bank[i]];
                bank_hit[req_bank[i]] = 1'b1;
                cmd_d[req_bank[i]] = req_cmd[i];
            end
        end
        for (int i = 0; i < num_reqs; i++) begin
            if (grants[i]) begin   // live traffic on the bank
                grant_to_busy = grant_to_busy | bank_hit[req_bank[i]]
                              | bank_cmd[req_bank[i]].valid
                              | bank_resp[req_bank[i]].valid;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            bank_release[b] = (bank_cmd[b].valid & bank_cmd[b].rd_wr & bank_cmd[b].wr_eos)
                            | (bank_resp[b].valid & bank_resp[b].eos);
        end
        busy_d = (bank_busy & ~bank_release) | bank_claim;
    end

    always_comb begin
        for (int i = 0; i < num_reqs; i++) begin
            masked_reqs[i] = req_on[i] & ~(bank_busy[req_bank[i]] | bank_hit[req_bank[i]]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_busy <= '0;
            bank_cmd  <= '0;
        end else begin
            bank_busy <= busy_d;
            bank_cmd  <= cmd_d;   // one cycle after grant_valid
        end
    end

    rr_arbiter #(
        .num_reqs (num_reqs)
    ) rr_arbiter_i (
        .clk    (clk),
        .reset  (reset),
        .reqs   (masked_reqs),
        .grants (grants)
    );

    no_busy_grant: assert property (@(posedge clk) disable iff (reset) !grant_to_busy)
        else $error("output_bus_arbiter: grant to busy bank, grants %b", grants);

    no_bank_collision: assert property (@(posedge clk) disable iff (reset) !cmd_collision)
        else $error("output_bus_arbiter: two commands on one bank");

endmodule

`default_nettype wire

//--- output_bus/output_sram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module output_sram_bank #(
    parameter int num_banks     = 4,
    parameter int rows_per_bank = 64
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire osram_bus_pkg::bank_cmd_t cmd,
    output osram_bus_pkg::bank_resp_t     resp
);

    localparam int bank_w    = $clog2(num_banks);
    localparam int row_w     = (rows_per_bank > 1) ? $clog2(rows_per_bank) : 1;
    localparam int word_w    = $clog2(osram_cfg_pkg::feat_words);
    localparam int last_word = osram_cfg_pkg::feat_words - 1;

    logic [osram_cfg_pkg::feat_w-1:0] mem [rows_per_bank][osram_cfg_pkg::feat_words];

    logic [row_w-1:0]  cmd_row;
    logic [word_w-1:0] wr_pos;
    logic [word_w-1:0] wr_word;    // next write slot
    logic              rd_active;
    logic [word_w-1:0] rd_cnt;
    logic [row_w-1:0]  rd_row;

    assign cmd_row = row_w'(cmd.node_id >> bank_w);   // bank bits dropped
    assign wr_pos  = cmd.wr_sos ? '0 : wr_word;

    always_ff @(posedge clk) begin
        if (cmd.valid && cmd.rd_wr) begin
            mem[cmd_row][wr_pos] <= cmd.data;
        end
    end

    // ----------------------------------------------------------
    // write slot counter and read stream
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_word    <= '0;
            rd_active  <= 1'b0;
            rd_cnt     <= '0;
            resp.valid <= 1'b0;
            resp.sos   <= 1'b0;
            resp.eos   <= 1'b0;
        end else begin
            resp.valid <= 1'b0;
            resp.sos   <= 1'b0;
            resp.eos   <= 1'b0;
            if (cmd.valid && cmd.rd_wr) begin
                wr_word <= wr_pos + 1'b1;
            end
            if (cmd.valid && !cmd.rd_wr) begin   // beat 0 straight off the command
                rd_active    <= 1'b1;
                rd_cnt       <= word_w'(1);
                rd_row       <= cmd_row;
                resp.valid   <= 1'b1;
                resp.sos     <= 1'b1;
                resp.pe_tag  <= cmd.pe_tag;
                resp.node_id <= cmd.node_id;
                resp.data    <= mem[cmd_row][0];
            end else if (rd_active) begin      // tag and node id hold
                resp.valid <= 1'b1;
                resp.eos   <= (rd_cnt == last_word);
                resp.data  <= mem[rd_row][rd_cnt];
                rd_cnt     <= rd_cnt + 1'b1;
                if (rd_cnt == last_word) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    no_cmd_during_read: assert property (@(posedge clk) disable iff (reset)
        cmd.valid |-> !rd_active)
        else $error("output_sram_bank: command for node %0d during read", cmd.node_id);

endmodule

`default_nettype wire

//--- src/output_sram_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module output_sram_subsystem #(
    parameter int num_edge_pe     = 2,
    parameter int num_vertex_unit = 2,
    parameter int num_banks       = 4
) (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire osram_bus_pkg::pe_req_t    [num_edge_pe-1:0]     pe_req,
    input  wire osram_bus_pkg::wr_req_t    [num_edge_pe-1:0]     edge_wr_req,
    input  wire osram_bus_pkg::wr_req_t    [num_vertex_unit-1:0] vertex_wr_req,
    output wire logic [2*num_edge_pe+num_vertex_unit-1:0]      grants,
    output wire osram_bus_pkg::bank_resp_t [num_banks-1:0]       bank_resp
);

    localparam int bank_w        = $clog2(num_banks);
    localparam int rows_per_bank = 2 ** (osram_cfg_pkg::node_id_w - bank_w);

    osram_bus_pkg::bank_cmd_t [num_banks-1:0] bank_cmd;   // registered in the arbiter

    // ----------------------------------------------------------
    // shared bus arbiter
    // ----------------------------------------------------------

    output_bus_arbiter #(
        .num_edge_pe     (num_edge_pe),
        .num_vertex_unit (num_vertex_unit),
        .num_banks       (num_banks)
    ) output_bus_arbiter_i (
        .clk           (clk),
        .reset         (reset),
        .pe_req        (pe_req),
        .edge_wr_req   (edge_wr_req),
        .vertex_wr_req (vertex_wr_req),
        .bank_resp     (bank_resp),   // eos frees the bank
        .bank_cmd      (bank_cmd),
        .grants        (grants)
    );

    // ----------------------------------------------------------
    // feature memory banks
    // ----------------------------------------------------------

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        output_sram_bank #(
            .num_banks     (num_banks),
            .rows_per_bank (rows_per_bank)
        ) output_sram_bank_i (
            .clk   (clk),
            .reset (reset),
            .cmd   (bank_cmd[b]),
            .resp  (bank_resp[b])
        );
    end

endmodule

`default_nettype wire

//--- src/rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [num_reqs-1:0] reqs,
    output logic      [num_reqs-1:0] grants
);

    localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    logic [ptr_w-1:0] ptr;       // highest priority index
    logic [ptr_w-1:0] next_ptr;

    always_comb begin
        int   idx;
        logic found;
        grants   = '0;
        next_ptr = ptr;
        found    = 1'b0;
        for (int off = 0; off < num_reqs; off++) begin
            idx = (int'(ptr) + off) % num_reqs;   // cyclic scan from ptr
            if (!found && reqs[idx]) begin
                found       = 1'b1;
                grants[idx] = 1'b1;
                next_ptr    = ptr_w'((idx + 1) % num_reqs);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (|grants) begin
            ptr <= next_ptr;   // just past the winner
        end
    end

    grant_legal: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grants) && ((grants & ~reqs) == '0))
        else $error("rr_arbiter: bad grants %b for reqs %b", grants, reqs);

endmodule

`default_nettype wire

//--- verification/output_sram_tb.sv
`timescale 1ns/100ps
`default_nettype none

module output_sram_tb;

    localparam int num_edge_pe     = 2;
    localparam int num_vertex_unit = 2;
    localparam int num_banks       = 4;
    localparam int num_reqs        = 2 * num_edge_pe + num_vertex_unit;
    localparam int num_wr          = num_edge_pe + num_vertex_unit;
    localparam int fw              = osram_cfg_pkg::feat_w;
    localparam int nw              = osram_cfg_pkg::feat_words;
    localparam int n_stim          = 20;
    localparam int max_cycles      = n_stim * 20;

    typedef struct {
        int                                  who;    // requester index
        bit                                  wr;
        logic [osram_cfg_pkg::node_id_w-1:0] node;
        logic [fw*nw-1:0]                    words;  // word k at [fw*k +: fw]
        bit                                  rnd;
        int                                  start;
    } stim_t;

    logic clk = 1'b0;
    logic reset;
    osram_bus_pkg::pe_req_t    [num_edge_pe-1:0] pe_req;
    osram_bus_pkg::wr_req_t    [num_wr-1:0]      wr_req;   // edge writers, then vertex units
    logic [num_reqs-1:0]                         grants;
    osram_bus_pkg::bank_resp_t [num_banks-1:0]   bank_resp;

    stim_t                               stim [n_stim];
    bit                                  taken [n_stim];
    logic [fw*nw-1:0]                    ref_mem [2**osram_cfg_pkg::node_id_w];
    int                                  phase [num_reqs];  // 0 idle 1 req 2 rd cmd 3 wr stream
    int                                  cur [num_reqs];
    int                                  beat [num_reqs];
    logic [fw*nw-1:0]                    row [num_reqs];
    int                                  free_at [num_banks];
    int                                  rd_beat [num_edge_pe] = '{-1, -1};
    int                                  rd_first [num_edge_pe];
    logic [osram_cfg_pkg::node_id_w-1:0] rd_node [num_edge_pe];
    int                                  rr_ptr = 0;
    int                                  cyc = 0;
    int                                  done_cnt = 0;
    int                                  seed = 32'hbec6;

    output_sram_subsystem #(
        .num_edge_pe     (num_edge_pe),
        .num_vertex_unit (num_vertex_unit),
        .num_banks       (num_banks)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .pe_req        (pe_req),
        .edge_wr_req   (wr_req[num_edge_pe-1:0]),
        .vertex_wr_req (wr_req[num_wr-1:num_edge_pe]),
        .grants        (grants),
        .bank_resp     (bank_resp)
    );

    always #4 clk = ~clk;

    initial begin
        reset  = 1'b1;
        pe_req = '0;
        wr_req = '0;
        // who, wr, node, words, rnd, start
        stim[0]  = '{5, 1'b1, 8'h07, 64'h0, 1'b1, 5};   // four banks right after reset
        stim[1]  = '{4, 1'b1, 8'h06, 64'h4444_3333_2222_1111, 1'b0, 5};
        stim[2]  = '{3, 1'b1, 8'h05, 64'h0, 1'b1, 5};
        stim[3]  = '{2, 1'b1, 8'h04, 64'h0, 1'b1, 5};
        stim[4]  = '{0, 1'b0, 8'h06, 64'h0, 1'b0, 20};  // all six with two bank clashes
        stim[5]  = '{1, 1'b0, 8'h04, 64'h0, 1'b0, 20};
        stim[6]  = '{2, 1'b1, 8'h0d, 64'h0, 1'b1, 20};
        stim[7]  = '{3, 1'b1, 8'h0f, 64'h0, 1'b1, 20};
        stim[8]  = '{4, 1'b1, 8'h08, 64'h0, 1'b1, 20};
        stim[9]  = '{5, 1'b1, 8'h0b, 64'h0, 1'b1, 20};
        stim[10] = '{2, 1'b1, 8'h0a, 64'h0, 1'b1, 40};  // bank 2 contention
        stim[11] = '{5, 1'b1, 8'h12, 64'hbeef_cafe_0123_4567, 1'b0, 41};
        stim[12] = '{1, 1'b0, 8'h0a, 64'h0, 1'b0, 43};
        stim[13] = '{0, 1'b0, 8'h12, 64'h0, 1'b0, 43};
        stim[14] = '{2, 1'b1, 8'h20, 64'h0, 1'b1, 70};  // parallel banks
        stim[15] = '{3, 1'b1, 8'h21, 64'h0, 1'b1, 70};
        stim[16] = '{4, 1'b1, 8'h22, 64'h0, 1'b1, 70};
        stim[17] = '{5, 1'b1, 8'h23, 64'h0, 1'b1, 70};
        stim[18] = '{0, 1'b0, 8'h21, 64'h0, 1'b0, 90};
        stim[19] = '{1, 1'b0, 8'h23, 64'h0, 1'b0, 90};
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // ----------------------------------------------------------
    // read response checks against the reference memory
    // ----------------------------------------------------------

    task automatic check_responses();
        osram_bus_pkg::bank_resp_t rsp;
        int                        t;
        for (int b = 0; b < num_banks; b++) begin
            rsp = bank_resp[b];
            t   = int'(rsp.pe_tag);
            if (rsp.valid) begin
                assert (t < num_edge_pe && rd_beat[t] >= 0)
                    else report_error($sformatf("bank %0d beat for idle tag %0d", b, t));
                assert (rsp.node_id == rd_node[t] && cyc == rd_first[t] + rd_beat[t])
                    else report_error($sformatf("tag %0d node %h at cycle %0d, expected %h at %0d",
                        t, rsp.node_id, cyc, rd_node[t], rd_first[t] + rd_beat[t]));
                assert (rsp.data === row[t][fw*rd_beat[t] +: fw])
                    else report_error($sformatf("tag %0d beat %0d data %h, expected %h",
                        t, rd_beat[t], rsp.data, row[t][fw*rd_beat[t] +: fw]));
                assert (rsp.sos == (rd_beat[t] == 0) && rsp.eos == (rd_beat[t] == nw - 1))
                    else report_error($sformatf("tag %0d beat %0d sos %b eos %b",
                        t, rd_beat[t], rsp.sos, rsp.eos));
                rd_beat[t] = rd_beat[t] + 1;
                if (rd_beat[t] == nw) begin
                    rd_beat[t] = -1;
                    done_cnt   = done_cnt + 1;
                end
            end
        end
    endtask

    // ----------------------------------------------------------
    // requester models
    // ----------------------------------------------------------

    task automatic step_requester(input int r);
        stim_t s;
        int    w;
        w = r - num_edge_pe;
        s = stim[cur[r]];
        case (phase[r])
            0: begin
                for (int i = 0; i < n_stim; i++) begin
                    if (phase[r] == 0 && !taken[i] && stim[i].who == r && stim[i].start <= cyc) begin
                        taken[i] = 1'b1;
                        cur[r]   = i;
                        phase[r] = 1;
                        if (stim[i].wr) begin
                            wr_req[w].req     <= 1'b1;
                            wr_req[w].node_id <= stim[i].node;
                        end else begin
                            pe_req[r].req     <= 1'b1;
                            pe_req[r].node_id <= stim[i].node;
                            pe_req[r].pe_tag  <= osram_cfg_pkg::pe_tag_w'(r);
                        end
                    end
                end
            end
            1: if (grants[r]) begin
                rr_ptr = (r + 1) % num_reqs;
                if (s.wr) begin
                    free_at[s.node % num_banks] = cyc + 6;   // last beat, command, release
                    row[r]          = s.rnd ? {$random(seed), $random(seed)} : s.words;
                    ref_mem[s.node] = row[r];
                    wr_req[w].req         <= 1'b0;
                    wr_req[w].grant_valid <= 1'b1;
                    wr_req[w].data        <= row[r][fw-1:0];
                    wr_req[w].sos         <= 1'b1;
                    beat[r]  = 1;
                    phase[r] = 3;
                end else begin
                    free_at[s.node % num_banks] = cyc + 7;   // response eos plus one
                    row[r]      = ref_mem[s.node];
                    rd_node[r]  = s.node;
                    rd_beat[r]  = 0;
                    rd_first[r] = cyc + 3;   // grant_valid, command, first beat
                    pe_req[r].req         <= 1'b0;
                    pe_req[r].grant_valid <= 1'b1;
                    phase[r] = 2;
                end
            end
            2: begin
                pe_req[r].grant_valid <= 1'b0;
                phase[r] = 0;
            end
            default: if (beat[r] < nw) begin
                wr_req[w].data <= row[r][fw*beat[r] +: fw];
                wr_req[w].sos  <= 1'b0;
                wr_req[w].eos  <= (beat[r] == nw - 1);
                beat[r] = beat[r] + 1;
            end else begin
                wr_req[w].grant_valid <= 1'b0;
                wr_req[w].eos         <= 1'b0;
                done_cnt = done_cnt + 1;
                phase[r] = 0;
            end
        endcase
    endtask

    always @(posedge clk) begin
        logic [num_reqs-1:0] exp_grants;
        logic                any_valid;
        int                  idx;
        exp_grants = '0;
        any_valid  = 1'b0;
        for (int b = 0; b < num_banks; b++) begin
            any_valid = any_valid | bank_resp[b].valid;
        end
        if (cyc >= 1 && cyc <= 4) begin
            assert (grants == '0 && !any_valid)
                else report_error($sformatf("grants %b or response valid in reset", grants));
        end else if (cyc > 4) begin
            check_responses();
            // cyclic scan from the pointer over requesters with a free bank
            for (int off = 0; off < num_reqs; off++) begin
                idx = (rr_ptr + off) % num_reqs;
                if (exp_grants == '0 && phase[idx] == 1
                        && cyc >= free_at[stim[cur[idx]].node % num_banks]) begin
                    exp_grants[idx] = 1'b1;
                end
            end
            assert ($onehot0(grants) && grants === exp_grants)
                else report_error($sformatf("cycle %0d grants %b, expected %b",
                    cyc, grants, exp_grants));
            for (int r = 0; r < num_reqs; r++) begin
                step_requester(r);
            end
        end
        cyc = cyc + 1;
    end

    always @(negedge clk) begin
        if (done_cnt == n_stim) begin
            $display("Test passed");
            $finish;
        end else if (cyc > max_cycles) begin
            $display("timeout: only %0d of %0d stimulus entries finished after %0d cycles",
                done_cnt, n_stim, cyc);
            $display("Test failed");
            $fatal(1, "run did not finish in time");
        end
    end

endmodule

`default_nettype wire
